//--- build.f
logic/core_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_stage.sv
logic/exec_core.sv
verification/exec_core_properties.sv
verification/exec_core_tb.sv

//--- logic/core_pkg.sv
// Shared widths, opcode and condition encodings, and pipeline records for the execute core
package core_pkg;

    // Data path and encoding widths
    localparam int word_width = 12;
    localparam int imm_width  = 6;
    localparam int reg_count  = 16;

    typedef logic [word_width-1:0] word_t;
    typedef logic [3:0]            reg_addr_t;

    // Bits 11 to 8 of the instruction word
    typedef enum logic [3:0] {
        mov    = 4'h0,
        add    = 4'h1,
        sub    = 4'h2,
        cmp    = 4'h3,
        inv    = 4'h4,
        and_op = 4'h5,
        or_op  = 4'h6,
        xor_op = 4'h7,
        shl    = 4'h8,
        shr    = 4'h9,
        sra    = 4'ha,
        li     = 4'hb,
        movi   = 4'hc,
        bcc    = 4'hd,
        st     = 4'he,
        hlt    = 4'hf
    } opcode_e;

    // Branch conditions, carried in the rd field of bcc
    // Codes above cc_ge are never taken
    typedef enum logic [3:0] {
        cc_always = 4'h0,
        cc_eq     = 4'h1,
        cc_ne     = 4'h2,
        cc_lt     = 4'h3,
        cc_gt     = 4'h4,
        cc_le     = 4'h5,
        cc_ge     = 4'h6
    } cond_e;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    // Decode stage output
    typedef struct packed {
        logic                 valid;
        opcode_e              op;
        reg_addr_t            rd;
        reg_addr_t            rs;
        cond_e                cond;
        logic                 hilo;
        logic [imm_width-1:0] imm;
        word_t                pc;
    } decoded_t;

    // Execute stage output, one record per executed instruction
    typedef struct packed {
        logic      valid;
        opcode_e   op;
        reg_addr_t rd;
        logic      wr_en;
        word_t     value;
        flags_t    flags;
        logic      store_en;
        word_t     store_data;
        logic      branch_taken;
        word_t     pc;
    } exec_result_t;

endpackage

//--- logic/exec_core.sv
// Top level of the execute core joining the decoder, register file and execute stage
module exec_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  core_pkg::word_t         instr,
    input  core_pkg::word_t         pc,
    output core_pkg::exec_result_t  result,
    output logic                    halted
);

    core_pkg::decoded_t     dec;
    core_pkg::reg_addr_t    rd_addr_a;
    core_pkg::reg_addr_t    rd_addr_b;
    core_pkg::reg_addr_t    wr_addr;
    core_pkg::word_t        rd_data_a;
    core_pkg::word_t        rd_data_b;
    core_pkg::word_t        wr_data;
    logic                   wr_en;

    instr_decoder decoder_i (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .instr  (instr),
        .pc     (pc),
        .halted (halted),
        .dec    (dec)
    );

    register_file regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // Execute writes the register file at the same edge it latches result
    execute_stage execute_i (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .result    (result),
        .halted    (halted)
    );

endmodule

//--- logic/execute_stage.sv
// Execute stage holding the ALU, branch conditions, immediate and flag registers and halt state
module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  core_pkg::decoded_t      dec,
    input  core_pkg::word_t         rd_data_a,
    input  core_pkg::word_t         rd_data_b,
    output core_pkg::reg_addr_t     rd_addr_a,
    output core_pkg::reg_addr_t     rd_addr_b,
    output logic                    wr_en,
    output core_pkg::reg_addr_t     wr_addr,
    output core_pkg::word_t         wr_data,
    output core_pkg::exec_result_t  result,
    output logic                    halted
);

    localparam int ww = core_pkg::word_width;
    localparam int iw = core_pkg::imm_width;

    core_pkg::word_t        op_a;
    core_pkg::word_t        op_b;
    logic [ww:0]            sum;
    core_pkg::word_t        value;
    core_pkg::word_t        store_data;
    core_pkg::word_t        imm_q;
    core_pkg::word_t        imm_next;
    core_pkg::word_t        br_offset;
    core_pkg::flags_t       flags_q;
    core_pkg::flags_t       flags_calc;
    core_pkg::flags_t       flags_next;
    core_pkg::exec_result_t result_next;
    logic                   carry;
    logic                   overflow;
    logic                   writes;
    logic                   flag_upd;
    logic                   cond_met;
    logic                   taken;
    logic                   is_store;
    logic                   is_halt;

    // Port a reads rd, port b reads rs
    assign rd_addr_a = dec.rd;
    assign rd_addr_b = dec.rs;
    assign op_a      = rd_data_a;
    assign op_b      = rd_data_b;

    assign br_offset = {{(ww - iw){imm_q[iw-1]}}, imm_q[iw-1:0]};

    // Condition check against the flags left by earlier instructions
    always_comb begin
        case (dec.cond)
            core_pkg::cc_always: cond_met = 1'b1;
            core_pkg::cc_eq:     cond_met = flags_q.z;
            core_pkg::cc_ne:     cond_met = !flags_q.z;
            core_pkg::cc_lt:     cond_met = flags_q.n ^ flags_q.v;
            core_pkg::cc_gt:     cond_met = !flags_q.z && !(flags_q.n ^ flags_q.v);
            core_pkg::cc_le:     cond_met = flags_q.z || (flags_q.n ^ flags_q.v);
            core_pkg::cc_ge:     cond_met = !(flags_q.n ^ flags_q.v);
            default:             cond_met = 1'b0;
        endcase
    end

    always_comb begin
        sum        = '0;
        value      = '0;
        store_data = '0;
        carry      = 1'b0;
        overflow   = 1'b0;
        writes     = 1'b0;
        flag_upd   = 1'b0;
        taken      = 1'b0;
        is_store   = 1'b0;
        is_halt    = 1'b0;
        imm_next   = imm_q;
        case (dec.op)
            core_pkg::mov: begin
                value  = op_b;
                writes = 1'b1;
            end
            core_pkg::add: begin
                sum      = {1'b0, op_a} + {1'b0, op_b};
                value    = sum[ww-1:0];
                carry    = sum[ww];
                overflow = !(op_a[ww-1] ^ op_b[ww-1]) && (value[ww-1] ^ op_a[ww-1]);
                writes   = 1'b1;
            end
            core_pkg::sub,
            core_pkg::cmp: begin
                // rd plus inverted rs plus one; cmp keeps only the flags
                sum      = {1'b0, op_a} + {1'b0, ~op_b} + {{ww{1'b0}}, 1'b1};
                value    = sum[ww-1:0];
                carry    = sum[ww];
                overflow = (op_a[ww-1] ^ op_b[ww-1]) && (value[ww-1] ^ op_a[ww-1]);
                writes   = (dec.op == core_pkg::sub);
                flag_upd = !writes;
            end
            core_pkg::inv: begin
                value  = ~op_a;
                writes = 1'b1;
            end
            core_pkg::and_op: begin
                value  = op_a & op_b;
                writes = 1'b1;
            end
            core_pkg::or_op: begin
                value  = op_a | op_b;
                writes = 1'b1;
            end
            core_pkg::xor_op: begin
                value  = op_a ^ op_b;
                writes = 1'b1;
            end
            core_pkg::shl: begin
                value  = op_a << op_b[3:0];
                writes = 1'b1;
            end
            core_pkg::shr: begin
                value  = op_a >> op_b[3:0];
                writes = 1'b1;
            end
            core_pkg::sra: begin
                value  = core_pkg::word_t'($signed(op_a) >>> op_b[3:0]);
                writes = 1'b1;
            end
            core_pkg::li: begin
                // hilo selects which half of the immediate register to load
                if (dec.hilo) begin
                    imm_next = {dec.imm, imm_q[iw-1:0]};
                end else begin
                    imm_next = {imm_q[ww-1:iw], dec.imm};
                end
            end
            core_pkg::movi: begin
                value  = imm_q;
                writes = 1'b1;
            end
            core_pkg::bcc: begin
                taken = cond_met;
                value = cond_met ? dec.pc + br_offset : dec.pc;
            end
            core_pkg::st: begin
                // Address from rd, data from rs
                value      = op_a;
                store_data = op_b;
                is_store   = 1'b1;
            end
            core_pkg::hlt: begin
                is_halt = 1'b1;
            end
        endcase
    end

    // Every register-writing op also sets the flags
    assign flags_calc = '{
        z: (value == '0),
        c: carry,
        n: value[ww-1],
        v: overflow
    };
    assign flags_next = (dec.valid && (writes || flag_upd)) ? flags_calc : flags_q;

    assign wr_en   = dec.valid && writes;
    assign wr_addr = dec.rd;
    assign wr_data = value;

    assign result_next = '{
        valid:        dec.valid,
        op:           dec.op,
        rd:           dec.rd,
        wr_en:        wr_en,
        value:        value,
        flags:        flags_next,
        store_en:     dec.valid && is_store,
        store_data:   store_data,
        branch_taken: dec.valid && taken,
        pc:           dec.pc
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= '0;
            imm_q   <= '0;
            halted  <= 1'b0;
            result  <= '0;
        end else begin
            flags_q <= flags_next;
            if (dec.valid) begin
                imm_q <= imm_next;
            end
            // Sticky until reset
            if (dec.valid && is_halt) begin
                halted <= 1'b1;
            end
            result <= result_next;
        end
    end

endmodule

//--- logic/instr_decoder.sv
// Decode stage that registers the fields of an issued instruction word for the execute stage
module instr_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  core_pkg::word_t      instr,
    input  core_pkg::word_t      pc,
    input  logic                 halted,
    output core_pkg::decoded_t   dec
);

    logic                               valid_q;
    logic                               hold;
    core_pkg::opcode_e                  op_q;
    core_pkg::reg_addr_t                rd_q;
    core_pkg::reg_addr_t                rs_q;
    core_pkg::cond_e                    cond_q;
    logic                               hilo_q;
    logic [core_pkg::imm_width-1:0]     imm_q;
    core_pkg::word_t                    pc_q;

    // Drop issues once halted, and also while a hlt sits in execute,
    // since halted only rises at the edge that retires it
    assign hold = halted || (valid_q && op_q == core_pkg::hlt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue && !hold;
        end
    end

    // Field registers only load on an issue
    always_ff @(posedge clk) begin
        if (issue) begin
            op_q   <= core_pkg::opcode_e'(instr[11:8]);
            rd_q   <= instr[7:4];
            rs_q   <= instr[3:0];
            cond_q <= core_pkg::cond_e'(instr[7:4]);
            hilo_q <= instr[6];
            imm_q  <= instr[5:0];
            pc_q   <= pc;
        end
    end

    assign dec = '{
        valid: valid_q,
        op:    op_q,
        rd:    rd_q,
        rs:    rs_q,
        cond:  cond_q,
        hilo:  hilo_q,
        imm:   imm_q,
        pc:    pc_q
    };

endmodule

//--- logic/register_file.sv
// General register file with two asynchronous read ports and one synchronous write port
module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::reg_addr_t   rd_addr_a,
    input  core_pkg::reg_addr_t   rd_addr_b,
    input  logic                  wr_en,
    input  core_pkg::reg_addr_t   wr_addr,
    input  core_pkg::word_t       wr_data,
    output core_pkg::word_t       rd_data_a,
    output core_pkg::word_t       rd_data_b
);

    core_pkg::word_t regs [core_pkg::reg_count];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old contents during a write; the new value
    // shows up after the edge
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- run_sim.sh
#!/bin/sh
# Compiles the exec_core testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module exec_core_tb -f build.f -o exec_core_sim
./obj_dir/exec_core_sim 2>&1 | tee sim.log
if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a pass report, see sim.log"
    exit 1
fi

//--- verification/exec_core_properties.sv
// Concurrent assertions bound into exec_core that watch its pipeline timing and output rules
module exec_core_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   issue,
    input logic                   halted,
    input core_pkg::decoded_t     dec,
    input core_pkg::exec_result_t result
);
    timeunit 1ns;
    timeprecision 100ps;

    no_valid_in_reset: assert property (@(posedge clk) rst |-> !result.valid)
        else $error("result.valid high while rst is asserted");

    // The decoder drops issues once halted and while a hlt sits in execute
    issue_latency: assert property (@(posedge clk) disable iff (rst)
        (issue && !halted && !(dec.valid && dec.op == core_pkg::hlt)) |-> ##2 result.valid)
        else $error("accepted issue did not give result.valid two cycles later");

    halted_sticky: assert property (@(posedge clk) (halted && !rst) |=> (halted || rst))
        else $error("halted fell without a reset");

    strobes_need_valid: assert property (@(posedge clk)
        (result.store_en || result.branch_taken) |-> result.valid)
        else $error("store_en or branch_taken high without result.valid");

endmodule

bind exec_core exec_core_properties props_i (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .halted (halted),
    .dec    (dec),
    .result (result)
);

//--- verification/exec_core_tb.sv
// Testbench that runs a seeded random instruction stream through exec_core against a model
module exec_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_instr = 2000;
    localparam int max_wait  = 200;

    logic                   clk;
    logic                   rst;
    logic                   issue;
    core_pkg::word_t        instr;
    core_pkg::word_t        pc;
    core_pkg::exec_result_t result;
    logic                   halted;

    // Reference model state, advanced at issue time since execution is in order
    core_pkg::word_t        model_regs [16];
    core_pkg::word_t        model_imm;
    core_pkg::flags_t       model_flags;
    core_pkg::exec_result_t expected [$];
    integer                 seed;
    logic [31:0]            rnd;
    int                     checked;
    int                     sent;
    int                     waited;

    exec_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_flags(input string name, input core_pkg::flags_t got,
                               input core_pkg::flags_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_result(input core_pkg::exec_result_t got,
                                input core_pkg::exec_result_t exp);
        logic [11:0] got_ctl;
        logic [11:0] exp_ctl;
        got_ctl = {got.valid, got.op, got.rd, got.wr_en, got.store_en, got.branch_taken};
        exp_ctl = {exp.valid, exp.op, exp.rd, exp.wr_en, exp.store_en, exp.branch_taken};
        if (got_ctl !== exp_ctl) begin
            abort_run($sformatf("ERR %0t result.{valid,op,rd,wr_en,store_en,branch_taken} %s",
                                $time, $sformatf("got=%h exp=%h", got_ctl, exp_ctl)));
        end
        check_word("result.pc", got.pc, exp.pc);
        check_flags("result.flags", got.flags, exp.flags);
        // Value carries no meaning for li, cmp and hlt
        if (!(exp.op inside {core_pkg::li, core_pkg::cmp, core_pkg::hlt})) begin
            check_word("result.value", got.value, exp.value);
        end
        if (exp.store_en) begin
            check_word("result.store_data", got.store_data, exp.store_data);
        end
    endtask

    // Applies one instruction to the model and returns the record it should produce
    function automatic core_pkg::exec_result_t model_step(input core_pkg::word_t ins,
                                                          input core_pkg::word_t at_pc);
        core_pkg::exec_result_t r;
        core_pkg::opcode_e      op;
        core_pkg::word_t        a;
        core_pkg::word_t        b;
        int                     wide;
        int                     sres;
        logic                   c;
        logic                   v;
        logic                   lt;
        logic                   met;
        op = core_pkg::opcode_e'(ins[11:8]);
        a  = model_regs[ins[7:4]];
        b  = model_regs[ins[3:0]];
        c  = 1'b0;
        v  = 1'b0;
        lt = model_flags.n ^ model_flags.v;
        r  = '0;
        r.valid = 1'b1;
        r.op    = op;
        r.rd    = ins[7:4];
        r.pc    = at_pc;
        case (op)
            core_pkg::add: begin
                wide    = int'(a) + int'(b);
                sres    = int'($signed(a)) + int'($signed(b));
                c       = wide[12];
                v       = (sres > 2047) || (sres < -2048);
                r.value = wide[11:0];
            end
            core_pkg::sub, core_pkg::cmp: begin
                wide    = int'(a) - int'(b);
                sres    = int'($signed(a)) - int'($signed(b));
                // Carry out is set when no borrow occurs
                c       = (a >= b);
                v       = (sres > 2047) || (sres < -2048);
                r.value = wide[11:0];
            end
            core_pkg::mov:    r.value = b;
            core_pkg::inv:    r.value = ~a;
            core_pkg::and_op: r.value = a & b;
            core_pkg::or_op:  r.value = a | b;
            core_pkg::xor_op: r.value = a ^ b;
            core_pkg::shl:    r.value = a << b[3:0];
            core_pkg::shr:    r.value = a >> b[3:0];
            core_pkg::sra: begin
                sres    = int'($signed(a)) >>> b[3:0];
                r.value = sres[11:0];
            end
            core_pkg::li: begin
                if (ins[6]) begin
                    model_imm[11:6] = ins[5:0];
                end else begin
                    model_imm[5:0] = ins[5:0];
                end
            end
            core_pkg::movi:   r.value = model_imm;
            core_pkg::bcc: begin
                case (core_pkg::cond_e'(ins[7:4]))
                    core_pkg::cc_always: met = 1'b1;
                    core_pkg::cc_eq:     met = model_flags.z;
                    core_pkg::cc_ne:     met = !model_flags.z;
                    core_pkg::cc_lt:     met = lt;
                    core_pkg::cc_gt:     met = !model_flags.z && !lt;
                    core_pkg::cc_le:     met = model_flags.z || lt;
                    core_pkg::cc_ge:     met = !lt;
                    default:             met = 1'b0;
                endcase
                r.branch_taken = met;
                r.value = met ? at_pc + {{6{model_imm[5]}}, model_imm[5:0]} : at_pc;
            end
            core_pkg::st: begin
                r.value      = a;
                r.store_data = b;
                r.store_en   = 1'b1;
            end
            default: begin
            end
        endcase
        r.wr_en = !(op inside {core_pkg::cmp, core_pkg::li, core_pkg::bcc, core_pkg::st,
                               core_pkg::hlt});
        if (r.wr_en) begin
            model_regs[ins[7:4]] = r.value;
        end
        if (r.wr_en || op == core_pkg::cmp) begin
            model_flags = '{z: (r.value == '0), c: c, n: r.value[11], v: v};
        end
        r.flags = model_flags;
        return r;
    endfunction

    // Any opcode except hlt with random register and condition fields
    function automatic core_pkg::word_t random_instr();
        logic [31:0] r;
        logic [3:0]  op;
        r  = $random(seed);
        op = r[3:0];
        if (op == core_pkg::hlt) begin
            op = r[7:4] & 4'he;
        end
        return {op, r[15:8]};
    endfunction

    // Issues one instruction with a random pc, and only tracked ones enter the model
    task automatic send(input core_pkg::word_t ins, input logic track);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        #1;
        issue = 1'b1;
        instr = ins;
        pc    = r[11:0];
        if (track) begin
            expected.push_back(model_step(ins, r[11:0]));
            sent++;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        issue = 1'b0;
        instr = random_instr();
    endtask

    // Sampled mid-cycle, away from the edge that updates the outputs
    always @(negedge clk) begin
        if (!rst && result.valid === 1'b1) begin
            if (expected.size() == 0) begin
                abort_run($sformatf("result at %0t with no instruction outstanding", $time));
            end else begin
                check_result(result, expected.pop_front());
                checked++;
            end
        end
    end

    initial begin
        seed        = 32'hb8ead462;
        rst         = 1'b1;
        issue       = 1'b0;
        instr       = '0;
        pc          = '0;
        checked     = 0;
        sent        = 0;
        model_imm   = '0;
        model_flags = '0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Load every register with a varied value through the immediate register
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            send({core_pkg::li, 2'b00, rnd[5:0]}, 1'b1);
            send({core_pkg::li, 2'b01, rnd[11:6]}, 1'b1);
            send({core_pkg::movi, 4'(i), 4'h0}, 1'b1);
        end

        // About three issues in four cycles
        while (sent < num_instr) begin
            rnd = $random(seed);
            if (rnd[1:0] != 2'b00) begin
                send(random_instr(), 1'b1);
            end else begin
                idle();
            end
        end

        waited = 0;
        while (expected.size() != 0 && waited < max_wait) begin
            idle();
            waited++;
        end
        if (expected.size() != 0) begin
            abort_run("results stopped arriving before the hlt was issued");
        end

        // Everything issued after hlt must be dropped
        send({core_pkg::hlt, 8'h00}, 1'b1);
        waited = 0;
        while (!halted && waited < max_wait) begin
            send(random_instr(), 1'b0);
            waited++;
        end
        if (!halted) begin
            abort_run("halted never rose after the hlt instruction");
        end
        if (waited != 2) begin
            abort_run($sformatf("halted rose %0d cycles after hlt instead of 2", waited));
        end
        repeat (50) begin
            send(random_instr(), 1'b0);
        end
        idle();
        idle();
        idle();
        if (expected.size() != 0 || checked != sent) begin
            abort_run($sformatf("checked %0d results out of %0d issued", checked, sent));
        end

        $display("%0d results checked", checked);
        $display("test passed");
        $finish;
    end

endmodule
